/* include/cgra_cfg_config.svh */
`ifndef CGRA_CFG_CONFIG_SVH
`define CGRA_CFG_CONFIG_SVH

// array size
`define CGRA_N_PE 4

// words buffered between host loader and bus dispatcher
`define CGRA_FIFO_DEPTH 8

// instruction slots per PE, addressed by instr_addr_t
`define CGRA_INSTR_DEPTH 256

// constant registers per PE, addressed by const_addr_t
`define CGRA_N_CONST 8

`endif

/* source/cgra_cfg_pkg.sv */
package cgra_cfg_pkg;

  typedef logic [15:0] pe_id_t;
  typedef logic [7:0]  instr_addr_t;
  typedef logic [15:0] instr_t;
  typedef logic [2:0]  const_addr_t;
  typedef logic [15:0] const_t;
  typedef logic [7:0]  pc_t;
  typedef logic [39:0] conf_data_t;

  typedef enum logic [3:0] {
    set_instruction = 4'd0,
    set_const       = 4'd1,
    set_pc_max      = 4'd2,
    set_loop        = 4'd3,
    set_ignore      = 4'd4,
    conf_nop        = 4'd15
  } conf_op_e;

  // per-opcode views of the data field, lowest field last
  typedef struct packed {
    logic [$bits(conf_data_t)-$bits(instr_t)-$bits(instr_addr_t)-1:0] pad;
    instr_t      instr;
    instr_addr_t addr;
  } instr_field_t;

  typedef struct packed {
    logic [$bits(conf_data_t)-$bits(const_t)-$bits(const_addr_t)-1:0] pad;
    const_t      value;
    const_addr_t idx;
  } const_field_t;

  typedef struct packed {
    logic [$bits(conf_data_t)-$bits(pc_t)-1:0] pad;
    pc_t value;
  } pc_field_t;

  // op sits in the low nibble of the bus
  typedef struct packed {
    conf_data_t data;
    pe_id_t     pe_id;
    conf_op_e   op;
  } conf_word_t;

  typedef struct packed {
    pc_t pc_max;
    pc_t pc_loop;
    pc_t ignore_until;
  } pe_ctrl_t;

  localparam conf_word_t conf_nop_word = '{data: '0, pe_id: '0, op: conf_nop};

endpackage

/* source/cfg_loader.sv */
`timescale 1ns/1ps

module cfg_loader (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     host_req,
  input  cgra_cfg_pkg::conf_word_t host_word,
  output logic                     host_ack,
  input  logic                     full,
  output logic                     push,
  output cgra_cfg_pkg::conf_word_t push_word
);

  typedef enum logic {
    wait_req,
    wait_release
  } state_e;

  state_e state;
  state_e state_nxt;

  // one word per req phase, held off while the fifo is full
  assign push      = (state == wait_req) && host_req && !full;
  assign push_word = host_word;

  // ack stays up until the host lets go of req
  assign host_ack = (state == wait_release);

  always_comb begin
    state_nxt = state;
    case (state)
      wait_req: begin
        if (push) begin
          state_nxt = wait_release;
        end
      end
      wait_release: begin
        if (!host_req) begin
          state_nxt = wait_req;
        end
      end
      default: begin
        state_nxt = wait_req;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wait_req;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

/* source/cfg_fifo.sv */
`timescale 1ns/1ps
`include "cgra_cfg_config.svh"

module cfg_fifo #(
  parameter int DEPTH = `CGRA_FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push,
  input  cgra_cfg_pkg::conf_word_t push_word,
  input  logic                     pop,
  output cgra_cfg_pkg::conf_word_t pop_word,
  output logic                     full,
  output logic                     empty
);
  import cgra_cfg_pkg::*;

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  conf_word_t       mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // wraps for any depth, not just powers of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full     = (count == cnt_w'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_word = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* source/cfg_dispatch.sv */
`timescale 1ns/1ps

module cfg_dispatch (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     empty,
  input  cgra_cfg_pkg::conf_word_t pop_word,
  output logic                     pop,
  output cgra_cfg_pkg::conf_word_t conf_bus,
  output logic [7:0]               bad_op_count
);
  import cgra_cfg_pkg::*;

  logic op_known;

  // drain one word per cycle, the bus never stalls
  assign pop = !empty;

  always_comb begin
    case (pop_word.op)
      set_instruction,
      set_const,
      set_pc_max,
      set_loop,
      set_ignore: begin
        op_known = 1'b1;
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      conf_bus     <= conf_nop_word;
      bad_op_count <= '0;
    end else begin
      // idle and rejected cycles both show a nop
      conf_bus <= conf_nop_word;
      if (pop && op_known) begin
        conf_bus <= pop_word;
      end
      // saturating count of dropped words
      if (pop && !op_known && (bad_op_count != 8'hff)) begin
        bad_op_count <= bad_op_count + 1'b1;
      end
    end
  end

endmodule

/* source/conf_reader_pe.sv */
`timescale 1ns/1ps

module conf_reader_pe #(
  parameter cgra_cfg_pkg::pe_id_t PE_ID = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  cgra_cfg_pkg::conf_word_t  conf_bus,
  output logic                      instr_we,
  output cgra_cfg_pkg::instr_addr_t instr_waddr,
  output cgra_cfg_pkg::instr_t      instr_wdata,
  output logic                      const_we,
  output cgra_cfg_pkg::const_addr_t const_waddr,
  output cgra_cfg_pkg::const_t      const_wdata,
  output cgra_cfg_pkg::pe_ctrl_t    ctrl
);
  import cgra_cfg_pkg::*;

  conf_word_t   bus_q;
  instr_field_t instr_f;
  const_field_t const_f;
  pc_field_t    pc_f;
  logic         for_me;

  assign instr_f = bus_q.data;
  assign const_f = bus_q.data;
  assign pc_f    = bus_q.data;
  assign for_me  = (bus_q.pe_id == PE_ID);

  // first stage, bus capture
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_q <= conf_nop_word;
    end else begin
      bus_q <= conf_bus;
    end
  end

  // second stage, decode
  always_ff @(posedge clk) begin
    if (rst) begin
      instr_we <= 1'b0;
      const_we <= 1'b0;
      ctrl     <= '0;
    end else begin
      instr_we <= for_me && (bus_q.op == set_instruction);
      const_we <= for_me && (bus_q.op == set_const);
      if (for_me) begin
        case (bus_q.op)
          set_pc_max: ctrl.pc_max       <= pc_f.value;
          set_loop:   ctrl.pc_loop      <= pc_f.value;
          set_ignore: ctrl.ignore_until <= pc_f.value;
          default:    ctrl              <= ctrl;
        endcase
      end
    end
  end

  // write payload, qualified by the enables above
  always_ff @(posedge clk) begin
    if (for_me && (bus_q.op == set_instruction)) begin
      instr_waddr <= instr_f.addr;
      instr_wdata <= instr_f.instr;
    end
    if (for_me && (bus_q.op == set_const)) begin
      const_waddr <= const_f.idx;
      const_wdata <= const_f.value;
    end
  end

endmodule

/* source/pe_conf_mem.sv */
`timescale 1ns/1ps
`include "cgra_cfg_config.svh"

module pe_conf_mem (
  input  logic                      clk,
  input  logic                      instr_we,
  input  cgra_cfg_pkg::instr_addr_t instr_waddr,
  input  cgra_cfg_pkg::instr_t      instr_wdata,
  input  logic                      const_we,
  input  cgra_cfg_pkg::const_addr_t const_waddr,
  input  cgra_cfg_pkg::const_t      const_wdata,
  input  cgra_cfg_pkg::instr_addr_t fetch_addr,
  input  cgra_cfg_pkg::const_addr_t const_raddr,
  output cgra_cfg_pkg::instr_t      fetch_instr,
  output cgra_cfg_pkg::const_t      const_rdata
);
  import cgra_cfg_pkg::*;

  instr_t instr_mem [`CGRA_INSTR_DEPTH];
  const_t const_rf  [`CGRA_N_CONST];

  // program store
  always_ff @(posedge clk) begin
    if (instr_we) begin
      instr_mem[instr_waddr] <= instr_wdata;
    end
  end

  // constant register file
  always_ff @(posedge clk) begin
    if (const_we) begin
      const_rf[const_waddr] <= const_wdata;
    end
  end

  // fetch side reads are asynchronous
  assign fetch_instr = instr_mem[fetch_addr];
  assign const_rdata = const_rf[const_raddr];

endmodule

/* source/cgra_cfg_top.sv */
`timescale 1ns/1ps
`include "cgra_cfg_config.svh"

module cgra_cfg_top (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        host_req,
  input  cgra_cfg_pkg::conf_word_t                    host_word,
  output logic                                        host_ack,
  input  cgra_cfg_pkg::instr_addr_t [`CGRA_N_PE-1:0]  fetch_addr,
  input  cgra_cfg_pkg::const_addr_t [`CGRA_N_PE-1:0]  const_raddr,
  output cgra_cfg_pkg::instr_t      [`CGRA_N_PE-1:0]  fetch_instr,
  output cgra_cfg_pkg::const_t      [`CGRA_N_PE-1:0]  const_rdata,
  output cgra_cfg_pkg::pe_ctrl_t    [`CGRA_N_PE-1:0]  ctrl,
  output logic                      [7:0]             bad_op_count
);
  import cgra_cfg_pkg::*;

  conf_word_t push_word;
  conf_word_t pop_word;
  conf_word_t conf_bus;
  logic       push;
  logic       pop;
  logic       full;
  logic       empty;

  cfg_loader u_loader (
    .clk       (clk),
    .rst       (rst),
    .host_req  (host_req),
    .host_word (host_word),
    .host_ack  (host_ack),
    .full      (full),
    .push      (push),
    .push_word (push_word)
  );

  cfg_fifo #(
    .DEPTH (`CGRA_FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_word (push_word),
    .pop       (pop),
    .pop_word  (pop_word),
    .full      (full),
    .empty     (empty)
  );

  cfg_dispatch u_dispatch (
    .clk          (clk),
    .rst          (rst),
    .empty        (empty),
    .pop_word     (pop_word),
    .pop          (pop),
    .conf_bus     (conf_bus),
    .bad_op_count (bad_op_count)
  );

  // one reader and config memory per PE, all on the same bus
  for (genvar i = 0; i < `CGRA_N_PE; i++) begin : g_pe
    logic        instr_we;
    instr_addr_t instr_waddr;
    instr_t      instr_wdata;
    logic        const_we;
    const_addr_t const_waddr;
    const_t      const_wdata;

    conf_reader_pe #(
      .PE_ID (pe_id_t'(i))
    ) u_reader (
      .clk         (clk),
      .rst         (rst),
      .conf_bus    (conf_bus),
      .instr_we    (instr_we),
      .instr_waddr (instr_waddr),
      .instr_wdata (instr_wdata),
      .const_we    (const_we),
      .const_waddr (const_waddr),
      .const_wdata (const_wdata),
      .ctrl        (ctrl[i])
    );

    pe_conf_mem u_mem (
      .clk         (clk),
      .instr_we    (instr_we),
      .instr_waddr (instr_waddr),
      .instr_wdata (instr_wdata),
      .const_we    (const_we),
      .const_waddr (const_waddr),
      .const_wdata (const_wdata),
      .fetch_addr  (fetch_addr[i]),
      .const_raddr (const_raddr[i]),
      .fetch_instr (fetch_instr[i]),
      .const_rdata (const_rdata[i])
    );
  end

endmodule

/* verif/cgra_cfg_sva.sv */
`timescale 1ns/1ps

module cgra_cfg_sva (
  input logic clk,
  input logic rst,
  input logic ack,
  input logic push,
  input logic full,
  input logic pop,
  input logic empty
);

  // ack only follows an accepted word
  ack_after_push: assert property (
    @(posedge clk) disable iff (rst) $rose(ack) |-> $past(push)
  ) else $error("host_ack rose without a push in the cycle before");

  no_push_when_full: assert property (
    @(posedge clk) disable iff (rst) !(push && full)
  ) else $error("push while the FIFO is full");

  no_pop_when_empty: assert property (
    @(posedge clk) disable iff (rst) !(pop && empty)
  ) else $error("pop while the FIFO is empty");

endmodule

// the loader has no pop side, the fifo no ack
bind cfg_loader cgra_cfg_sva u_loader_sva (
  .clk   (clk),
  .rst   (rst),
  .ack   (host_ack),
  .push  (push),
  .full  (full),
  .pop   (1'b0),
  .empty (1'b1)
);

bind cfg_fifo cgra_cfg_sva u_fifo_sva (
  .clk   (clk),
  .rst   (rst),
  .ack   (1'b0),
  .push  (push),
  .full  (full),
  .pop   (pop),
  .empty (empty)
);

/* verif/cgra_cfg_tb.sv */
`timescale 1ns/1ps
`include "cgra_cfg_config.svh"

module cgra_cfg_tb;
  import cgra_cfg_pkg::*;

  localparam int N_PE          = `CGRA_N_PE;
  localparam int RESET_CYCLES  = 8;
  localparam int SETTLE_CYCLES = 6;
  localparam int ACK_TIMEOUT   = 200;

  typedef struct {
    string      name;
    conf_word_t word;
    bit         hold;
  } stim_t;

  logic                   clk;
  logic                   rst;
  logic                   host_req;
  conf_word_t             host_word;
  logic                   host_ack;
  instr_addr_t [N_PE-1:0] fetch_addr;
  const_addr_t [N_PE-1:0] const_raddr;
  instr_t      [N_PE-1:0] fetch_instr;
  const_t      [N_PE-1:0] const_rdata;
  pe_ctrl_t    [N_PE-1:0] ctrl;
  logic        [7:0]      bad_op_count;

  // scoreboard
  instr_t     exp_instr   [N_PE][`CGRA_INSTR_DEPTH];
  bit         instr_known [N_PE][`CGRA_INSTR_DEPTH];
  const_t     exp_const   [N_PE][`CGRA_N_CONST];
  bit         const_known [N_PE][`CGRA_N_CONST];
  pe_ctrl_t   exp_ctrl    [N_PE];
  logic [7:0] exp_bad;

  stim_t  stim_q[$];
  integer seed;

  cgra_cfg_top i_dut (.*);

  always #10 clk = ~clk;

  function automatic conf_word_t make_word(input logic [3:0] op, input int pe,
                                           input logic [39:0] data);
    conf_word_t w;
    w.op    = conf_op_e'(op);
    w.pe_id = pe_id_t'(pe);
    w.data  = data;
    return w;
  endfunction

  function automatic instr_t rand16();
    return 16'($random(seed));
  endfunction

  task automatic add_entry(input string name, input logic [3:0] op, input int pe,
                           input logic [39:0] data, input bit hold);
    stim_t e;
    e.name = name;
    e.word = make_word(op, pe, data);
    e.hold = hold;
    stim_q.push_back(e);
  endtask

  // decode as the bus word format defines it
  function automatic void model_apply(input conf_word_t w);
    logic [3:0] op;
    int         pe;
    op = w.op;
    pe = int'(w.pe_id);
    if (op > 4'd4) begin
      if (exp_bad != 8'hff) begin
        exp_bad = exp_bad + 8'd1;
      end
    end else if (pe < N_PE) begin
      case (op)
        4'd0: begin
          exp_instr[pe][w.data[7:0]]   = w.data[23:8];
          instr_known[pe][w.data[7:0]] = 1'b1;
        end
        4'd1: begin
          exp_const[pe][w.data[2:0]]   = w.data[18:3];
          const_known[pe][w.data[2:0]] = 1'b1;
        end
        4'd2:    exp_ctrl[pe].pc_max       = w.data[7:0];
        4'd3:    exp_ctrl[pe].pc_loop      = w.data[7:0];
        default: exp_ctrl[pe].ignore_until = w.data[7:0];
      endcase
    end
  endfunction

  task automatic fail_run();
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      fail_run();
    end
  endtask

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (host_ack !== level) begin
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        $display("host_ack did not go to %0b within %0d cycles", level, ACK_TIMEOUT);
        fail_run();
      end
      @(negedge clk);
    end
  endtask

  // four-phase host side
  task automatic send_word(input conf_word_t w);
    @(posedge clk);
    host_word <= w;
    host_req  <= 1'b1;
    wait_ack(1'b1);
    @(posedge clk);
    host_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  // walks every slot, constants ride along on the low addresses
  task automatic check_state(input string name);
    @(negedge clk);
    check_value($sformatf("%s bad_op_count", name), 32'(exp_bad), 32'(bad_op_count));
    for (int p = 0; p < N_PE; p++) begin
      check_value($sformatf("%s pe%0d ctrl", name, p), 32'(exp_ctrl[p]), 32'(ctrl[p]));
    end
    for (int a = 0; a < `CGRA_INSTR_DEPTH; a++) begin
      @(posedge clk);
      for (int p = 0; p < N_PE; p++) begin
        fetch_addr[p]  <= instr_addr_t'(a);
        const_raddr[p] <= const_addr_t'(a);
      end
      @(negedge clk);
      for (int p = 0; p < N_PE; p++) begin
        if (instr_known[p][a]) begin
          check_value($sformatf("%s pe%0d instr[%0d]", name, p, a),
                      32'(exp_instr[p][a]), 32'(fetch_instr[p]));
        end
        if (a < `CGRA_N_CONST && const_known[p][a]) begin
          check_value($sformatf("%s pe%0d const[%0d]", name, p, a),
                      32'(exp_const[p][a]), 32'(const_rdata[p]));
        end
      end
    end
  endtask

  task automatic build_table();
    // instruction data is {instr, addr}, constants {value, idx}
    add_entry("instr pe0 slot5", set_instruction, 0, {16'h0, rand16(), 8'd5}, 1'b0);
    add_entry("instr pe1 slot5", set_instruction, 1, {16'h0, rand16(), 8'd5}, 1'b0);
    add_entry("instr pe3 slot200", set_instruction, 3, {16'h0, rand16(), 8'd200}, 1'b0);
    add_entry("instr pe2 random", set_instruction, 2, {16'h0, rand16(), 8'(rand16())}, 1'b0);
    add_entry("const pe1 idx3", set_const, 1, {21'h0, 16'h1111, 3'd3}, 1'b0);
    add_entry("const pe3 idx3", set_const, 3, {21'h0, 16'h2222, 3'd3}, 1'b0);
    add_entry("const pe2 idx7", set_const, 2, {21'h0, rand16(), 3'd7}, 1'b0);
    add_entry("const pe0 idx0", set_const, 0, {21'h0, rand16(), 3'd0}, 1'b0);
    add_entry("pc_max pe2", set_pc_max, 2, {32'h0, 8'h10}, 1'b0);
    add_entry("loop pe2", set_loop, 2, {32'h0, 8'h04}, 1'b0);
    add_entry("ignore pe2", set_ignore, 2, {32'h0, 8'h02}, 1'b0);
    add_entry("pc_max pe2 again", set_pc_max, 2, {32'h0, 8'h20}, 1'b0);
    add_entry("loop pe0", set_loop, 0, {32'h0, 8'h33}, 1'b0);
    add_entry("unknown opcode", 4'd7, 1, {16'h0, 16'hdead, 8'd5}, 1'b0);
    add_entry("no such pe instr", set_instruction, 9, {16'h0, 16'hbad0, 8'd5}, 1'b0);
    add_entry("no such pe pc_max", set_pc_max, 9, {32'h0, 8'h55}, 1'b0);
    // burst well past the FIFO depth, last two overwrite
    for (int k = 0; k < 10; k++) begin
      add_entry($sformatf("burst %0d", k), set_instruction, 1,
                {16'h0, rand16(), 8'(40 + k)}, 1'b1);
    end
    add_entry("burst rewrite 40", set_instruction, 1, {16'h0, 16'hbeef, 8'd40}, 1'b1);
    add_entry("burst rewrite 41", set_instruction, 1, {16'h0, 16'hcafe, 8'd41}, 1'b0);
  endtask

  task automatic run_table();
    int pending;
    pending = 0;
    foreach (stim_q[i]) begin
      send_word(stim_q[i].word);
      model_apply(stim_q[i].word);
      pending++;
      if (!stim_q[i].hold) begin
        repeat (SETTLE_CYCLES * pending) @(posedge clk);
        check_state(stim_q[i].name);
        pending = 0;
      end
    end
  endtask

  // reset hits with ack up, req held and a ctrl word still on the bus
  task automatic reset_midstream();
    conf_word_t w;
    send_word(make_word(set_pc_max, 3, {32'h0, 8'h77}));
    send_word(make_word(4'd9, 3, {32'h0, 8'h01}));
    @(posedge clk);
    host_word <= make_word(set_loop, 3, {32'h0, 8'h12});
    host_req  <= 1'b1;
    wait_ack(1'b1);
    @(posedge clk);
    rst <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst      <= 1'b0;
    host_req <= 1'b0;
    for (int p = 0; p < N_PE; p++) begin
      exp_ctrl[p] = '0;
    end
    exp_bad = '0;
    @(negedge clk);
    check_value("reset host_ack", 32'h0, 32'(host_ack));
    check_state("after reset");
    w = make_word(set_instruction, 3, {16'h0, 16'h5a5a, 8'd9});
    send_word(w);
    model_apply(w);
    repeat (SETTLE_CYCLES) @(posedge clk);
    check_state("handshake after reset");
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    host_req    = 1'b0;
    host_word   = '0;
    fetch_addr  = '0;
    const_raddr = '0;
    seed        = 32'h5f03;
    for (int p = 0; p < N_PE; p++) begin
      exp_ctrl[p] = '0;
    end
    exp_bad = '0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    run_table();
    reset_midstream();
    $display("all tests passed");
    $finish;
  end

endmodule

/* cgra_cfg_top.f */
+incdir+include
source/cgra_cfg_pkg.sv
source/cfg_loader.sv
source/cfg_fifo.sv
source/cfg_dispatch.sv
source/conf_reader_pe.sv
source/pe_conf_mem.sv
source/cgra_cfg_top.sv
verif/cgra_cfg_sva.sv
verif/cgra_cfg_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f cgra_cfg_top.f --top-module cgra_cfg_tb --Mdir obj_dir -o Vcgra_cfg_tb
./obj_dir/Vcgra_cfg_tb > sim.log 2>&1 || true
cat sim.log
if grep -qx "all tests passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
